// File: trace_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared definitions for the instruction tracer
// instruction class and record writer state enums
// RV32I major opcodes and instruction field positions
// trace record size and word 2 field layout
//////////////////////////////////////////////////////////////////////

`default_nettype none

package trace_pkg;

  localparam int XLEN      = 32;
  localparam int REC_WORDS = 5;
  localparam int STAMP_W   = 16;
  localparam int CLASS_W   = 4;

  // instruction fields
  localparam int RD_LSB   = 7;
  localparam int OPCODE_W = 7;

  typedef enum logic [CLASS_W-1:0] {
    CLS_LUI     = 4'd0,
    CLS_AUIPC   = 4'd1,
    CLS_JAL     = 4'd2,
    CLS_JALR    = 4'd3,
    CLS_BRANCH  = 4'd4,
    CLS_LOAD    = 4'd5,
    CLS_STORE   = 4'd6,
    CLS_OP_IMM  = 4'd7,
    CLS_OP      = 4'd8,
    CLS_FENCE   = 4'd9,
    CLS_SYSTEM  = 4'd10,
    CLS_INVALID = 4'd15
  } instr_class_e;

  typedef enum logic [2:0] {
    WR_IDLE  = 3'd0,
    WR_WORD0 = 3'd1,
    WR_WORD1 = 3'd2,
    WR_WORD2 = 3'd3,
    WR_WORD3 = 3'd4,
    WR_WORD4 = 3'd5
  } wr_state_e;

  //////////////////////////////////////////////////////////////////////
  // RV32I major opcodes
  //////////////////////////////////////////////////////////////////////
  localparam logic [OPCODE_W-1:0] OPC_LUI    = 7'b0110111;
  localparam logic [OPCODE_W-1:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [OPCODE_W-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [OPCODE_W-1:0] OPC_JALR   = 7'b1100111;
  localparam logic [OPCODE_W-1:0] OPC_BRANCH = 7'b1100011;
  localparam logic [OPCODE_W-1:0] OPC_LOAD   = 7'b0000011;
  localparam logic [OPCODE_W-1:0] OPC_STORE  = 7'b0100011;
  localparam logic [OPCODE_W-1:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [OPCODE_W-1:0] OPC_OP     = 7'b0110011;
  localparam logic [OPCODE_W-1:0] OPC_FENCE  = 7'b0001111;
  localparam logic [OPCODE_W-1:0] OPC_SYSTEM = 7'b1110011;

  // record word 2, bits 15:12 are reserved and read as zero
  localparam int W2_CLASS_LSB = 0;
  localparam int W2_RD_LSB    = 4;
  localparam int W2_WR_VALID  = 9;
  localparam int W2_MEM_VALID = 10;
  localparam int W2_MEM_WE    = 11;
  localparam int W2_STAMP_LSB = 16;

endpackage

`default_nettype wire

// File: trace_decoder.sv
//////////////////////////////////////////////////////////////////////
// decode stage capture for the instruction tracer
// free running cycle counter for timestamps
// major opcode classification and in-order entry queue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trace_decoder
  import trace_pkg::*;
#(
  parameter int QUEUE_DEPTH = 8
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                id_valid,
  input  wire                is_decoding,
  input  wire  [XLEN-1:0]    pc,
  input  wire  [XLEN-1:0]    instr,
  input  wire                pop,
  output logic               valid,
  output logic [XLEN-1:0]    head_pc,
  output logic [XLEN-1:0]    head_instr,
  output instr_class_e       head_class,
  output logic [STAMP_W-1:0] head_stamp,
  output logic               overflow
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  logic [STAMP_W-1:0]  cycle_cnt;
  logic [OPCODE_W-1:0] opcode;
  instr_class_e        cls;
  logic                event_dec;
  logic                full;
  logic [PTR_W:0]      wr_ptr;
  logic [PTR_W:0]      rd_ptr;

  logic [XLEN-1:0]    q_pc    [QUEUE_DEPTH];
  logic [XLEN-1:0]    q_instr [QUEUE_DEPTH];
  instr_class_e       q_class [QUEUE_DEPTH];
  logic [STAMP_W-1:0] q_stamp [QUEUE_DEPTH];

  assign event_dec = id_valid && is_decoding;
  assign opcode    = instr[RD_LSB-1:RD_LSB-OPCODE_W];

  // timestamp source, wraps silently
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // 32-bit encodings only, compressed forms fall to invalid
  always_comb begin
    cls = CLS_INVALID;
    if (opcode[1:0] == 2'b11) begin
      case (opcode)
        OPC_LUI:    cls = CLS_LUI;
        OPC_AUIPC:  cls = CLS_AUIPC;
        OPC_JAL:    cls = CLS_JAL;
        OPC_JALR:   cls = CLS_JALR;
        OPC_BRANCH: cls = CLS_BRANCH;
        OPC_LOAD:   cls = CLS_LOAD;
        OPC_STORE:  cls = CLS_STORE;
        OPC_OP_IMM: cls = CLS_OP_IMM;
        OPC_OP:     cls = CLS_OP;
        OPC_FENCE:  cls = CLS_FENCE;
        OPC_SYSTEM: cls = CLS_SYSTEM;
        default:    cls = CLS_INVALID;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // circular queue
  //////////////////////////////////////////////////////////////////////
  assign full  = (wr_ptr - rd_ptr) == (PTR_W+1)'(QUEUE_DEPTH);
  assign valid = wr_ptr != rd_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (event_dec && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // entry lost, flag stays until reset
      if (event_dec && full) begin
        overflow <= 1'b1;
      end
      if (pop && valid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (event_dec && !full) begin
      q_pc[wr_ptr[PTR_W-1:0]]    <= pc;
      q_instr[wr_ptr[PTR_W-1:0]] <= instr;
      q_class[wr_ptr[PTR_W-1:0]] <= cls;
      q_stamp[wr_ptr[PTR_W-1:0]] <= cycle_cnt;
    end
  end

  assign head_pc    = q_pc[rd_ptr[PTR_W-1:0]];
  assign head_instr = q_instr[rd_ptr[PTR_W-1:0]];
  assign head_class = q_class[rd_ptr[PTR_W-1:0]];
  assign head_stamp = q_stamp[rd_ptr[PTR_W-1:0]];

  // the writer only takes an entry that is there
  a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> valid);

  a_class_known: assert property (@(posedge clk) disable iff (!rst_n)
    valid |-> !$isunknown(head_class));

endmodule

`default_nettype wire

// File: result_collector.sv
//////////////////////////////////////////////////////////////////////
// execute and writeback capture for the instruction tracer
// one pending data access between retirements
// in-order result queue, one entry per wb_valid pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module result_collector
  import trace_pkg::*;
#(
  parameter int QUEUE_DEPTH = 8
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             ex_data_req,
  input  wire             ex_data_gnt,
  input  wire             ex_data_we,
  input  wire  [XLEN-1:0] ex_data_addr,
  input  wire             wb_valid,
  input  wire             wb_reg_we,
  input  wire  [4:0]      wb_reg_addr,
  input  wire  [XLEN-1:0] wb_reg_wdata,
  input  wire             pop,
  output logic            valid,
  output logic            head_wr_valid,
  output logic [4:0]      head_wr_addr,
  output logic [XLEN-1:0] head_wr_data,
  output logic            head_mem_valid,
  output logic            head_mem_we,
  output logic [XLEN-1:0] head_mem_addr,
  output logic            overflow
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  logic            access;
  logic            pend_valid;
  logic            pend_we;
  logic [XLEN-1:0] pend_addr;
  logic            full;
  logic [PTR_W:0]  wr_ptr;
  logic [PTR_W:0]  rd_ptr;

  logic            q_wr_valid  [QUEUE_DEPTH];
  logic [4:0]      q_wr_addr   [QUEUE_DEPTH];
  logic [XLEN-1:0] q_wr_data   [QUEUE_DEPTH];
  logic            q_mem_valid [QUEUE_DEPTH];
  logic            q_mem_we    [QUEUE_DEPTH];
  logic [XLEN-1:0] q_mem_addr  [QUEUE_DEPTH];

  assign access = ex_data_req && ex_data_gnt;

  //////////////////////////////////////////////////////////////////////
  // pending access
  //////////////////////////////////////////////////////////////////////
  // an access on the retiring edge belongs to the next instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_valid <= 1'b0;
    end else if (wb_valid) begin
      pend_valid <= access;
    end else if (access) begin
      pend_valid <= 1'b1;
    end
  end

  // later accesses before retirement are ignored
  always_ff @(posedge clk) begin
    if (access && (wb_valid || !pend_valid)) begin
      pend_we   <= ex_data_we;
      pend_addr <= ex_data_addr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // result queue
  //////////////////////////////////////////////////////////////////////
  assign full  = (wr_ptr - rd_ptr) == (PTR_W+1)'(QUEUE_DEPTH);
  assign valid = wr_ptr != rd_ptr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (wb_valid && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (wb_valid && full) begin
        overflow <= 1'b1;
      end
      if (pop && valid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // x0 is never a real write
  always_ff @(posedge clk) begin
    if (wb_valid && !full) begin
      q_wr_valid[wr_ptr[PTR_W-1:0]]  <= wb_reg_we && (wb_reg_addr != 5'd0);
      q_wr_addr[wr_ptr[PTR_W-1:0]]   <= wb_reg_addr;
      q_wr_data[wr_ptr[PTR_W-1:0]]   <= wb_reg_wdata;
      q_mem_valid[wr_ptr[PTR_W-1:0]] <= pend_valid;
      q_mem_we[wr_ptr[PTR_W-1:0]]    <= pend_we;
      q_mem_addr[wr_ptr[PTR_W-1:0]]  <= pend_addr;
    end
  end

  assign head_wr_valid  = q_wr_valid[rd_ptr[PTR_W-1:0]];
  assign head_wr_addr   = q_wr_addr[rd_ptr[PTR_W-1:0]];
  assign head_wr_data   = q_wr_data[rd_ptr[PTR_W-1:0]];
  assign head_mem_valid = q_mem_valid[rd_ptr[PTR_W-1:0]];
  assign head_mem_we    = q_mem_we[rd_ptr[PTR_W-1:0]];
  assign head_mem_addr  = q_mem_addr[rd_ptr[PTR_W-1:0]];

endmodule

`default_nettype wire

// File: record_writer.sv
//////////////////////////////////////////////////////////////////////
// trace record writer
// joins decoder and collector heads into five-word records
// Wishbone classic master with a wrapping buffer pointer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module record_writer
  import trace_pkg::*;
#(
  parameter logic [XLEN-1:0] BUF_BASE  = 32'h0000_1000,
  parameter int              BUF_WORDS = 64
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                dec_valid,
  input  wire  [XLEN-1:0]    dec_pc,
  input  wire  [XLEN-1:0]    dec_instr,
  input  var   instr_class_e dec_class,
  input  wire  [STAMP_W-1:0] dec_stamp,
  input  wire                res_valid,
  input  wire                res_wr_valid,
  input  wire  [4:0]         res_wr_addr,
  input  wire  [XLEN-1:0]    res_wr_data,
  input  wire                res_mem_valid,
  input  wire                res_mem_we,
  input  wire  [XLEN-1:0]    res_mem_addr,
  input  wire                wb_ack,
  output logic               dec_pop,
  output logic               res_pop,
  output logic               wb_cyc,
  output logic               wb_stb,
  output logic               wb_we,
  output logic [XLEN-1:0]    wb_adr,
  output logic [XLEN-1:0]    wb_dat
);

  localparam logic [XLEN-1:0] BUF_LAST = BUF_BASE + XLEN'(BUF_WORDS) - 1'b1;

  wr_state_e       state;
  logic            pop_q;
  logic [2:0]      word_idx;
  logic [XLEN-1:0] ptr;
  logic [XLEN-1:0] word2;
  logic [XLEN-1:0] rec_word [REC_WORDS];

  // status word built from both heads
  always_comb begin
    word2 = '0;
    word2[W2_CLASS_LSB +: CLASS_W]  = dec_class;
    word2[W2_RD_LSB +: 5]           = res_wr_addr;
    word2[W2_WR_VALID]              = res_wr_valid;
    word2[W2_MEM_VALID]             = res_mem_valid;
    word2[W2_MEM_WE]                = res_mem_valid && res_mem_we;
    word2[W2_STAMP_LSB +: STAMP_W]  = dec_stamp;
  end

  //////////////////////////////////////////////////////////////////////
  // record FSM
  //////////////////////////////////////////////////////////////////////
  assign word_idx = state - 3'd1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= WR_IDLE;
      pop_q <= 1'b0;
      ptr   <= BUF_BASE;
    end else begin
      pop_q <= 1'b0;
      case (state)
        WR_IDLE: begin
          // heads are latched on the pop edge
          if (pop_q) begin
            state <= WR_WORD0;
          end else if (dec_valid && res_valid) begin
            pop_q <= 1'b1;
          end
        end
        default: begin
          if (wb_ack) begin
            ptr <= (ptr == BUF_LAST) ? BUF_BASE : ptr + 1'b1;
            if (word_idx == 3'(REC_WORDS - 1)) begin
              state <= WR_IDLE;
            end else begin
              state <= wr_state_e'(state + 3'd1);
            end
          end
        end
      endcase
    end
  end

  // unused fields forced to zero
  always_ff @(posedge clk) begin
    if (pop_q) begin
      rec_word[0] <= dec_pc;
      rec_word[1] <= dec_instr;
      rec_word[2] <= word2;
      rec_word[3] <= res_wr_valid ? res_wr_data : '0;
      rec_word[4] <= res_mem_valid ? res_mem_addr : '0;
    end
  end

  assign dec_pop = pop_q;
  assign res_pop = pop_q;

  // cyc held for the whole record
  assign wb_cyc = state != WR_IDLE;
  assign wb_stb = state != WR_IDLE;
  assign wb_we  = state != WR_IDLE;
  assign wb_adr = ptr;
  assign wb_dat = (state == WR_IDLE) ? '0 : rec_word[word_idx];

  // next word of the same record follows right after an ack
  a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && wb_ack && state != WR_WORD4 |=> wb_cyc && wb_stb);

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat));

endmodule

`default_nettype wire

// File: instr_tracer.sv
//////////////////////////////////////////////////////////////////////
// instruction tracer top level
// decoder and result collector feeding the record writer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module instr_tracer
  import trace_pkg::*;
#(
  parameter int              QUEUE_DEPTH = 8,
  parameter logic [XLEN-1:0] BUF_BASE    = 32'h0000_1000,
  parameter int              BUF_WORDS   = 64
) (
  input  wire             clk,
  input  wire             rst_n,
  // decode stage
  input  wire             id_valid,
  input  wire             is_decoding,
  input  wire  [XLEN-1:0] pc,
  input  wire  [XLEN-1:0] instr,
  // execute and writeback
  input  wire             ex_data_req,
  input  wire             ex_data_gnt,
  input  wire             ex_data_we,
  input  wire  [XLEN-1:0] ex_data_addr,
  input  wire             wb_valid,
  input  wire             wb_reg_we,
  input  wire  [4:0]      wb_reg_addr,
  input  wire  [XLEN-1:0] wb_reg_wdata,
  // trace buffer bus
  output logic            wb_cyc,
  output logic            wb_stb,
  output logic            wb_we,
  output logic [XLEN-1:0] wb_adr,
  output logic [XLEN-1:0] wb_dat,
  input  wire             wb_ack,
  output logic            decode_overflow,
  output logic            result_overflow
);

  logic               dec_valid;
  logic [XLEN-1:0]    dec_pc;
  logic [XLEN-1:0]    dec_instr;
  instr_class_e       dec_class;
  logic [STAMP_W-1:0] dec_stamp;
  logic               dec_pop;

  logic               res_valid;
  logic               res_wr_valid;
  logic [4:0]         res_wr_addr;
  logic [XLEN-1:0]    res_wr_data;
  logic               res_mem_valid;
  logic               res_mem_we;
  logic [XLEN-1:0]    res_mem_addr;
  logic               res_pop;

  trace_decoder #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) dec0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_valid    (id_valid),
    .is_decoding (is_decoding),
    .pc          (pc),
    .instr       (instr),
    .pop         (dec_pop),
    .valid       (dec_valid),
    .head_pc     (dec_pc),
    .head_instr  (dec_instr),
    .head_class  (dec_class),
    .head_stamp  (dec_stamp),
    .overflow    (decode_overflow)
  );

  result_collector #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) res0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_data_req    (ex_data_req),
    .ex_data_gnt    (ex_data_gnt),
    .ex_data_we     (ex_data_we),
    .ex_data_addr   (ex_data_addr),
    .wb_valid       (wb_valid),
    .wb_reg_we      (wb_reg_we),
    .wb_reg_addr    (wb_reg_addr),
    .wb_reg_wdata   (wb_reg_wdata),
    .pop            (res_pop),
    .valid          (res_valid),
    .head_wr_valid  (res_wr_valid),
    .head_wr_addr   (res_wr_addr),
    .head_wr_data   (res_wr_data),
    .head_mem_valid (res_mem_valid),
    .head_mem_we    (res_mem_we),
    .head_mem_addr  (res_mem_addr),
    .overflow       (result_overflow)
  );

  record_writer #(
    .BUF_BASE  (BUF_BASE),
    .BUF_WORDS (BUF_WORDS)
  ) wr0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .dec_valid     (dec_valid),
    .dec_pc        (dec_pc),
    .dec_instr     (dec_instr),
    .dec_class     (dec_class),
    .dec_stamp     (dec_stamp),
    .res_valid     (res_valid),
    .res_wr_valid  (res_wr_valid),
    .res_wr_addr   (res_wr_addr),
    .res_wr_data   (res_wr_data),
    .res_mem_valid (res_mem_valid),
    .res_mem_we    (res_mem_we),
    .res_mem_addr  (res_mem_addr),
    .wb_ack        (wb_ack),
    .dec_pop       (dec_pop),
    .res_pop       (res_pop),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat        (wb_dat)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset source
// 4 ns clock, reset held low for the first 16 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_NS      = 2,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // released on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_instr_tracer.sv
//////////////////////////////////////////////////////////////////////
// testbench for the instruction tracer
// random core model with up to four instructions in flight
// Wishbone slave model with random ack delay and a trace buffer
// reference records, per-test summary and cycle watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_instr_tracer
  import trace_pkg::*;
();

  localparam int              QUEUE_DEPTH = 8;
  localparam logic [XLEN-1:0] BUF_BASE    = 32'h0000_1000;
  localparam int              BUF_WORDS   = 64;
  localparam int              SWEEP_N     = 16;
  localparam int              RANDOM_N    = 60;
  localparam int              STALL_N     = 40;
  localparam int              TIMEOUT     = 200 * (SWEEP_N + RANDOM_N + STALL_N) + 1000;
  localparam int unsigned     SEED        = 32'h2857;

  typedef struct packed {
    logic [XLEN-1:0] w0;
    logic [XLEN-1:0] w1;
    logic [XLEN-1:0] w2;
    logic [XLEN-1:0] w3;
    logic [XLEN-1:0] w4;
  } rec_t;

  logic clk;
  logic rst_n;

  logic            id_valid;
  logic            is_decoding;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] instr;
  logic            ex_data_req;
  logic            ex_data_gnt;
  logic            ex_data_we;
  logic [XLEN-1:0] ex_data_addr;
  logic            wb_valid;
  logic            wb_reg_we;
  logic [4:0]      wb_reg_addr;
  logic [XLEN-1:0] wb_reg_wdata;
  logic            wb_cyc;
  logic            wb_stb;
  logic            wb_we;
  logic [XLEN-1:0] wb_adr;
  logic [XLEN-1:0] wb_dat;
  logic            wb_ack = 1'b0;
  logic            decode_overflow;
  logic            result_overflow;

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          records = 0;
  int          wraps = 0;
  int          tb_cycles = 0;
  int          run_cycles = 0;
  int          ack_wait = -1;
  int          word_cnt = 0;
  int          rec_start = 0;
  int unsigned first_draw;
  logic        hold_ack = 1'b0;
  logic        have_prev = 1'b0;
  logic [15:0] prev_exp_stamp;
  logic [15:0] prev_act_stamp;
  logic [XLEN-1:0] exp_ptr = BUF_BASE;
  logic [XLEN-1:0] buf_mem [BUF_WORDS];

  // pending data access of the oldest instruction in flight
  logic            acc_valid = 1'b0;
  logic            acc_we;
  logic [XLEN-1:0] acc_addr;

  // instructions decoded but not yet retired
  logic [XLEN-1:0] fl_pc [$];
  logic [XLEN-1:0] fl_instr [$];
  logic [15:0]     fl_stamp [$];
  int              fl_ready [$];
  rec_t            exp_q [$];

  tb_clock_gen clk0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  instr_tracer #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .BUF_BASE    (BUF_BASE),
    .BUF_WORDS   (BUF_WORDS)
  ) dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .id_valid        (id_valid),
    .is_decoding     (is_decoding),
    .pc              (pc),
    .instr           (instr),
    .ex_data_req     (ex_data_req),
    .ex_data_gnt     (ex_data_gnt),
    .ex_data_we      (ex_data_we),
    .ex_data_addr    (ex_data_addr),
    .wb_valid        (wb_valid),
    .wb_reg_we       (wb_reg_we),
    .wb_reg_addr     (wb_reg_addr),
    .wb_reg_wdata    (wb_reg_wdata),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat          (wb_dat),
    .wb_ack          (wb_ack),
    .decode_overflow (decode_overflow),
    .result_overflow (result_overflow)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model helpers
  //////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [XLEN-1:0] exp_val,
                             input logic [XLEN-1:0] act_val);
    checks++;
    if (exp_val !== act_val) begin
      errors++;
      $display("[FAIL] %s exp %h act %h", name, exp_val, act_val);
    end
  endtask

  // entries 11 and up are not RV32I major opcodes
  function automatic logic [OPCODE_W-1:0] opcode_at(input int idx);
    case (idx)
      0:       return OPC_LUI;
      1:       return OPC_AUIPC;
      2:       return OPC_JAL;
      3:       return OPC_JALR;
      4:       return OPC_BRANCH;
      5:       return OPC_LOAD;
      6:       return OPC_STORE;
      7:       return OPC_OP_IMM;
      8:       return OPC_OP;
      9:       return OPC_FENCE;
      10:      return OPC_SYSTEM;
      11:      return 7'b0001011;
      12:      return 7'b1111111;
      13:      return 7'b0000000;
      14:      return 7'b1010101;
      default: return 7'b0101111;
    endcase
  endfunction

  function automatic instr_class_e expect_class(input logic [XLEN-1:0] ins);
    case (ins[OPCODE_W-1:0])
      OPC_LUI:    return CLS_LUI;
      OPC_AUIPC:  return CLS_AUIPC;
      OPC_JAL:    return CLS_JAL;
      OPC_JALR:   return CLS_JALR;
      OPC_BRANCH: return CLS_BRANCH;
      OPC_LOAD:   return CLS_LOAD;
      OPC_STORE:  return CLS_STORE;
      OPC_OP_IMM: return CLS_OP_IMM;
      OPC_OP:     return CLS_OP;
      OPC_FENCE:  return CLS_FENCE;
      OPC_SYSTEM: return CLS_SYSTEM;
      default:    return CLS_INVALID;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // core model, called right after a falling edge
  //////////////////////////////////////////////////////////////////////
  // random noise that never forms a decode, access or retire
  task automatic drive_idle();
    id_valid     = 1'($urandom_range(0, 1));
    is_decoding  = 1'b0;
    pc           = $urandom;
    instr        = $urandom;
    ex_data_req  = 1'($urandom_range(0, 1));
    ex_data_gnt  = 1'b0;
    ex_data_we   = 1'($urandom_range(0, 1));
    ex_data_addr = $urandom;
    wb_valid     = 1'b0;
    wb_reg_we    = 1'($urandom_range(0, 1));
    wb_reg_addr  = 5'($urandom);
    wb_reg_wdata = $urandom;
  endtask

  task automatic decode_one(input logic [OPCODE_W-1:0] opc);
    logic [XLEN-1:0] ins;
    ins = $urandom;
    ins[OPCODE_W-1:0] = opc;
    if ($urandom_range(0, 5) == 0) begin
      ins[RD_LSB +: 5] = 5'd0;
    end
    id_valid    = 1'b1;
    is_decoding = 1'b1;
    pc          = $urandom & 32'hffff_fffc;
    instr       = ins;
    fl_pc.push_back(pc);
    fl_instr.push_back(ins);
    fl_stamp.push_back(16'(tb_cycles));
    fl_ready.push_back(tb_cycles + $urandom_range(1, 4));
  endtask

  task automatic drive_access();
    ex_data_req  = 1'b1;
    ex_data_gnt  = ($urandom_range(0, 3) != 0);
    ex_data_we   = 1'($urandom_range(0, 1));
    ex_data_addr = $urandom;
    // only the first granted access counts
    if (ex_data_gnt && !acc_valid) begin
      acc_valid = 1'b1;
      acc_we    = ex_data_we;
      acc_addr  = ex_data_addr;
    end
  endtask

  task automatic retire_one();
    logic [XLEN-1:0] ins;
    logic [XLEN-1:0] w2;
    logic [15:0]     stamp;
    logic [4:0]      rd;
    logic            wr_ok;
    rec_t            rec;
    rec.w0 = fl_pc.pop_front();
    ins    = fl_instr.pop_front();
    stamp  = fl_stamp.pop_front();
    void'(fl_ready.pop_front());
    rd = ins[RD_LSB +: 5];
    wb_valid     = 1'b1;
    wb_reg_we    = ($urandom_range(0, 3) != 0);
    wb_reg_addr  = rd;
    wb_reg_wdata = $urandom;
    wr_ok = wb_reg_we && (rd != 5'd0);
    w2 = '0;
    w2[W2_CLASS_LSB +: CLASS_W] = expect_class(ins);
    w2[W2_RD_LSB +: 5]          = rd;
    w2[W2_WR_VALID]             = wr_ok;
    w2[W2_MEM_VALID]            = acc_valid;
    w2[W2_MEM_WE]               = acc_valid && acc_we;
    w2[W2_STAMP_LSB +: STAMP_W] = stamp;
    rec.w1 = ins;
    rec.w2 = w2;
    rec.w3 = wr_ok ? wb_reg_wdata : '0;
    rec.w4 = acc_valid ? acc_addr : '0;
    exp_q.push_back(rec);
    acc_valid = 1'b0;
  endtask

  // decode room is kept so that neither queue can overflow
  task automatic run_core(input int n, input bit sweep);
    int decoded;
    int retired;
    logic [OPCODE_W-1:0] opc;
    decoded = 0;
    retired = 0;
    while (retired < n) begin
      @(negedge clk);
      drive_idle();
      if (fl_pc.size() > 0 && tb_cycles >= fl_ready[0] && $urandom_range(0, 2) != 0) begin
        retire_one();
        retired++;
      end else if (fl_pc.size() > 0 && $urandom_range(0, 2) == 0) begin
        drive_access();
      end
      if (decoded < n && fl_pc.size() < 4 && fl_pc.size() + exp_q.size() < QUEUE_DEPTH - 1
          && $urandom_range(0, 1) == 1) begin
        if (sweep) begin
          opc = opcode_at(decoded % 16);
        end else if ($urandom_range(0, 3) == 0) begin
          opc = 7'($urandom);
        end else begin
          opc = opcode_at($urandom_range(0, 15));
        end
        decode_one(opc);
        decoded++;
      end
    end
    @(negedge clk);
    drive_idle();
  endtask

  task automatic wait_drain();
    while (exp_q.size() > 0 || wb_cyc) begin
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Wishbone slave model
  //////////////////////////////////////////////////////////////////////
  task automatic compare_record();
    rec_t            exp_rec;
    logic [XLEN-1:0] got [REC_WORDS];
    logic [15:0]     exp_delta;
    logic [15:0]     act_delta;
    int              k;
    for (k = 0; k < REC_WORDS; k++) begin
      got[k] = buf_mem[(rec_start + k) % BUF_WORDS];
    end
    if (exp_q.size() == 0) begin
      errors++;
      $display("record written at offset %0d with no retired instruction", rec_start);
    end else begin
      exp_rec = exp_q.pop_front();
      check_value("word0_pc", exp_rec.w0, got[0]);
      check_value("word1_instr", exp_rec.w1, got[1]);
      check_value("word2_flags", {16'h0, exp_rec.w2[15:0]}, {16'h0, got[2][15:0]});
      check_value("word3_wdata", exp_rec.w3, got[3]);
      check_value("word4_mem_addr", exp_rec.w4, got[4]);
      if (have_prev) begin
        exp_delta = exp_rec.w2[31:16] - prev_exp_stamp;
        act_delta = got[2][31:16] - prev_act_stamp;
        check_value("stamp_delta", 32'(exp_delta), 32'(act_delta));
      end
      have_prev      = 1'b1;
      prev_exp_stamp = exp_rec.w2[31:16];
      prev_act_stamp = got[2][31:16];
      records++;
    end
  endtask

  task automatic store_word();
    int idx;
    check_value("wb_cyc", 32'd1, 32'(wb_cyc));
    check_value("wb_we", 32'd1, 32'(wb_we));
    check_value("wb_adr", exp_ptr, wb_adr);
    idx = int'((wb_adr - BUF_BASE) % BUF_WORDS);
    if (word_cnt == 0) begin
      rec_start = idx;
    end
    buf_mem[idx] = wb_dat;
    if (exp_ptr == BUF_BASE + BUF_WORDS - 1) begin
      exp_ptr = BUF_BASE;
      wraps++;
    end else begin
      exp_ptr = exp_ptr + 1;
    end
    word_cnt++;
    if (word_cnt == REC_WORDS) begin
      compare_record();
      word_cnt = 0;
    end
  endtask

  // ack after 0 to 3 idle cycles, word stored on the ack decision
  always @(negedge clk) begin
    wb_ack = 1'b0;
    if (rst_n && wb_stb && !hold_ack) begin
      if (ack_wait < 0) begin
        ack_wait = $urandom_range(0, 3);
      end
      if (ack_wait == 0) begin
        store_word();
        wb_ack   = 1'b1;
        ack_wait = -1;
      end else begin
        ack_wait--;
      end
    end
  end

  // model cycle count, equals the stamp of the next rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      tb_cycles <= tb_cycles + 1;
    end
  end

  always @(posedge clk) begin
    run_cycles++;
    if (run_cycles >= TIMEOUT) begin
      $display("timeout: run stopped after %0d cycles", run_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////
  task automatic report_test(input string name, input int err_start, input int rec_start_cnt);
    tests++;
    $display("test %0d %s: %0d records, %0d errors", tests, name,
             records - rec_start_cnt, errors - err_start);
  endtask

  // ack held low while decodes keep coming, one record waits on the bus
  task automatic stall_test();
    int k;
    @(posedge clk);
    hold_ack = 1'b1;
    @(negedge clk);
    drive_idle();
    decode_one(OPC_OP);
    for (k = 1; k < STALL_N; k++) begin
      @(negedge clk);
      drive_idle();
      if (k == 2) begin
        retire_one();
      end
      decode_one(opcode_at($urandom_range(0, 15)));
    end
    @(negedge clk);
    drive_idle();
    check_value("decode_overflow", 32'd1, 32'(decode_overflow));
    check_value("result_overflow", 32'd0, 32'(result_overflow));
    check_value("wb_stb_held", 32'd1, 32'(wb_stb));
    @(posedge clk);
    hold_ack = 1'b0;
    // these never retire
    fl_pc.delete();
    fl_instr.delete();
    fl_stamp.delete();
    fl_ready.delete();
    wait_drain();
    repeat (20) @(negedge clk);
    check_value("decode_overflow", 32'd1, 32'(decode_overflow));
  endtask

  initial begin
    int err_start;
    int rec_cnt;
    first_draw = $urandom(SEED);
    drive_idle();
    id_valid    = 1'b0;
    ex_data_req = 1'b0;
    @(posedge rst_n);
    @(negedge clk);

    err_start = errors;
    rec_cnt   = records;
    check_value("wb_cyc", 32'd0, 32'(wb_cyc));
    check_value("wb_stb", 32'd0, 32'(wb_stb));
    check_value("wb_adr", BUF_BASE, wb_adr);
    check_value("decode_overflow", 32'd0, 32'(decode_overflow));
    check_value("result_overflow", 32'd0, 32'(result_overflow));
    report_test("reset values", err_start, rec_cnt);

    err_start = errors;
    rec_cnt   = records;
    run_core(SWEEP_N, 1'b1);
    wait_drain();
    report_test("opcode sweep", err_start, rec_cnt);

    err_start = errors;
    rec_cnt   = records;
    run_core(RANDOM_N, 1'b0);
    wait_drain();
    if (wraps == 0) begin
      errors++;
      $display("buffer pointer never wrapped back to the base address");
    end
    report_test("random traffic", err_start, rec_cnt);

    err_start = errors;
    rec_cnt   = records;
    stall_test();
    report_test("ack stall", err_start, rec_cnt);

    $display("tests %0d, records %0d, checks %0d, errors %0d", tests, records, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
trace_pkg.sv
trace_decoder.sv
result_collector.sv
record_writer.sv
instr_tracer.sv
tb_clock_gen.sv
tb_instr_tracer.sv

// File: run.sh
#!/bin/sh
# build and run the instruction tracer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_instr_tracer -f sim.f -o tb_instr_tracer_sim

./obj_dir/tb_instr_tracer_sim > sim.log 2>&1
cat sim.log

# the log alone decides the result
if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
exit 1
